// File: Makefile
VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: common/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// data width
`define XLEN 32

// machine-mode csr addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

// SYSTEM opcode and its funct3 codes
`define OPC_SYSTEM  7'b1110011
`define F3_PRIV     3'b000
`define F3_CSRRW    3'b001
`define F3_CSRRS    3'b010
`define F3_CSRRC    3'b011
`define F3_CSRRWI   3'b101
`define F3_CSRRSI   3'b110
`define F3_CSRRCI   3'b111

// full encodings under funct3 000
`define INSTR_ECALL 32'h0000_0073
`define INSTR_MRET  32'h3020_0073

// MPP = 3, machine mode only
`define MSTATUS_RST 32'h0000_1800

// mcause codes
`define CAUSE_ECALL   4'd11
`define CAUSE_ILLEGAL 4'd2

`endif

// File: common/csr_pkg.sv
`include "csr_cfg.svh"

package csr_pkg;

    // one data word
    typedef logic [`XLEN-1:0] xlen_t;

    // csr address field
    typedef logic [11:0] csr_addr_t;

    // raw instruction word
    typedef logic [31:0] instr_t;

    // exception code, only the low bits of mcause are ever set by a trap
    typedef logic [3:0] cause_t;

    // decoded operation
    typedef enum logic [2:0] {
        OP_NONE,
        // read-write, read-set, read-clear
        OP_RW,
        OP_RS,
        OP_RC,
        // environment call, trap to mtvec
        OP_ECALL,
        // return from machine trap
        OP_MRET,
        // bad funct3, bad csr address or unknown priv encoding
        OP_ILLEGAL
    } csr_op_e;

endpackage

// File: compile.f
+incdir+common
common/csr_pkg.sv
csr_unit/csr_decode.sv
csr_unit/csr_file.sv
csr_unit/csr_result.sv
csr_unit/csr_unit_top.sv
dv/csr_clk_gen.sv
dv/csr_assert.sv
dv/csr_tb.sv

// File: csr_unit/csr_decode.sv
`include "csr_cfg.svh"

module csr_decode (
    input  logic               valid_i,
    input  csr_pkg::instr_t    instr_i,
    input  csr_pkg::xlen_t     rs1_data_i,
    output csr_pkg::csr_op_e   op_o,
    output csr_pkg::csr_addr_t addr_o,
    output csr_pkg::xlen_t     operand_o,
    output logic               wr_req_o,
    output logic               rd_we_o,
    output csr_pkg::cause_t    cause_o
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [4:0]        rs1_field;
    logic [4:0]        rd_field;
    logic              addr_ok;
    logic              is_csr_op;
    csr_pkg::csr_op_e  csr_op;

    assign opcode    = instr_i[6:0];
    assign rd_field  = instr_i[11:7];
    assign funct3    = instr_i[14:12];
    assign rs1_field = instr_i[19:15];
    assign addr_o    = instr_i[31:20];

    // only the four implemented registers are legal
    always_comb begin
        case (addr_o)
            `CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE: addr_ok = 1'b1;
            default: addr_ok = 1'b0;
        endcase
    end

    // register and immediate forms share an operation
    always_comb begin
        case (funct3)
            `F3_CSRRW, `F3_CSRRWI: csr_op = csr_pkg::OP_RW;
            `F3_CSRRS, `F3_CSRRSI: csr_op = csr_pkg::OP_RS;
            `F3_CSRRC, `F3_CSRRCI: csr_op = csr_pkg::OP_RC;
            default: csr_op = csr_pkg::OP_NONE;
        endcase
    end

    // uimm lives in the rs1 field, zero extended
    assign operand_o = funct3[2] ? {{(`XLEN-5){1'b0}}, rs1_field} : rs1_data_i;

    always_comb begin
        op_o = csr_pkg::OP_NONE;
        if (valid_i && opcode == `OPC_SYSTEM) begin
            if (funct3 == `F3_PRIV) begin
                if (instr_i == `INSTR_ECALL) begin
                    op_o = csr_pkg::OP_ECALL;
                end else if (instr_i == `INSTR_MRET) begin
                    op_o = csr_pkg::OP_MRET;
                end else begin
                    op_o = csr_pkg::OP_ILLEGAL;
                end
            end else if (csr_op == csr_pkg::OP_NONE || !addr_ok) begin
                op_o = csr_pkg::OP_ILLEGAL;
            end else begin
                op_o = csr_op;
            end
        end
    end

    assign is_csr_op = (op_o == csr_pkg::OP_RW) || (op_o == csr_pkg::OP_RS) ||
                       (op_o == csr_pkg::OP_RC);

    // set/clear with x0 or uimm 0 is a pure read
    assign wr_req_o = (op_o == csr_pkg::OP_RW) ||
                      (is_csr_op && rs1_field != 5'd0);

    assign rd_we_o = is_csr_op && (rd_field != 5'd0);

    always_comb begin
        case (op_o)
            csr_pkg::OP_ECALL:   cause_o = `CAUSE_ECALL;
            csr_pkg::OP_ILLEGAL: cause_o = `CAUSE_ILLEGAL;
            default: cause_o = '0;
        endcase
    end

endmodule

// File: csr_unit/csr_file.sv
`include "csr_cfg.svh"

module csr_file (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::xlen_t     pc_i,
    input  csr_pkg::csr_op_e   op_i,
    input  csr_pkg::csr_addr_t addr_i,
    input  csr_pkg::xlen_t     operand_i,
    input  logic               wr_req_i,
    input  csr_pkg::cause_t    cause_i,
    output csr_pkg::xlen_t     rdata_o,
    output csr_pkg::xlen_t     target_pc_o
);

    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;

    // writable bits per register
    localparam csr_pkg::xlen_t MSTATUS_WMASK = (`XLEN'(1) << MIE_BIT) |
                                               (`XLEN'(1) << MPIE_BIT);
    localparam csr_pkg::xlen_t ALIGN_MASK    = ~`XLEN'(3);

    csr_pkg::xlen_t mstatus_q;
    csr_pkg::xlen_t mtvec_q;
    csr_pkg::xlen_t mepc_q;
    csr_pkg::xlen_t mcause_q;
    csr_pkg::xlen_t wdata;
    logic           trap;
    logic           mret;

    assign trap = (op_i == csr_pkg::OP_ECALL) || (op_i == csr_pkg::OP_ILLEGAL);
    assign mret = (op_i == csr_pkg::OP_MRET);

    // old value, before any write this cycle
    always_comb begin
        case (addr_i)
            `CSR_MSTATUS: rdata_o = mstatus_q;
            `CSR_MTVEC:   rdata_o = mtvec_q;
            `CSR_MEPC:    rdata_o = mepc_q;
            `CSR_MCAUSE:  rdata_o = mcause_q;
            default: rdata_o = '0;
        endcase
    end

    // read-modify-write value
    always_comb begin
        case (op_i)
            csr_pkg::OP_RS: wdata = rdata_o | operand_i;
            csr_pkg::OP_RC: wdata = rdata_o & ~operand_i;
            default: wdata = operand_i;
        endcase
    end

    // only MIE and MPIE move, MPP stays at its reset value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= `MSTATUS_RST;
        end else if (trap) begin
            mstatus_q[MPIE_BIT] <= mstatus_q[MIE_BIT];
            mstatus_q[MIE_BIT]  <= 1'b0;
        end else if (mret) begin
            mstatus_q[MIE_BIT]  <= mstatus_q[MPIE_BIT];
            mstatus_q[MPIE_BIT] <= 1'b1;
        end else if (wr_req_i && addr_i == `CSR_MSTATUS) begin
            mstatus_q <= (mstatus_q & ~MSTATUS_WMASK) | (wdata & MSTATUS_WMASK);
        end
    end

    // direct mode, base is word aligned
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_q <= '0;
        end else if (wr_req_i && addr_i == `CSR_MTVEC) begin
            mtvec_q <= wdata & ALIGN_MASK;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_q <= '0;
        end else if (trap) begin
            mepc_q <= pc_i & ALIGN_MASK;
        end else if (wr_req_i && addr_i == `CSR_MEPC) begin
            mepc_q <= wdata & ALIGN_MASK;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcause_q <= '0;
        end else if (trap) begin
            mcause_q <= csr_pkg::xlen_t'(cause_i);
        end else if (wr_req_i && addr_i == `CSR_MCAUSE) begin
            mcause_q <= wdata;
        end
    end

    // redirect target, zero when nothing redirects
    always_comb begin
        if (trap) begin
            target_pc_o = mtvec_q;
        end else if (mret) begin
            target_pc_o = mepc_q;
        end else begin
            target_pc_o = '0;
        end
    end

endmodule

// File: csr_unit/csr_result.sv
`include "csr_cfg.svh"

module csr_result (
    input  logic             clk,
    input  logic             rst_n,
    input  csr_pkg::csr_op_e op_i,
    input  logic             rd_we_i,
    input  csr_pkg::xlen_t   rdata_i,
    input  csr_pkg::xlen_t   target_pc_i,
    output logic             rd_we_o,
    output csr_pkg::xlen_t   rd_data_o,
    output logic             redirect_o,
    output csr_pkg::xlen_t   redirect_pc_o
);

    logic is_redirect;
    logic is_csr_op;

    // traps and mret change the fetch path
    assign is_redirect = (op_i == csr_pkg::OP_ECALL) ||
                         (op_i == csr_pkg::OP_ILLEGAL) ||
                         (op_i == csr_pkg::OP_MRET);

    assign is_csr_op = (op_i == csr_pkg::OP_RW) ||
                       (op_i == csr_pkg::OP_RS) ||
                       (op_i == csr_pkg::OP_RC);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_we_o    <= 1'b0;
            redirect_o <= 1'b0;
        end else begin
            rd_we_o    <= rd_we_i;
            redirect_o <= is_redirect;
        end
    end

    // data only for a real csr access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data_o <= '0;
        end else if (is_csr_op) begin
            rd_data_o <= rdata_i;
        end else begin
            rd_data_o <= '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_pc_o <= '0;
        end else if (is_redirect) begin
            redirect_pc_o <= target_pc_i;
        end else begin
            redirect_pc_o <= '0;
        end
    end

endmodule

// File: csr_unit/csr_unit_top.sv
module csr_unit_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            valid_i,
    input  csr_pkg::instr_t instr_i,
    input  csr_pkg::xlen_t  pc_i,
    input  csr_pkg::xlen_t  rs1_data_i,
    output logic            rd_we_o,
    output csr_pkg::xlen_t  rd_data_o,
    output logic            redirect_o,
    output csr_pkg::xlen_t  redirect_pc_o
);

    csr_pkg::csr_op_e   op;
    csr_pkg::csr_addr_t addr;
    csr_pkg::xlen_t     operand;
    logic               wr_req;
    logic               rd_we;
    csr_pkg::cause_t    cause;
    csr_pkg::xlen_t     rdata;
    csr_pkg::xlen_t     target_pc;

    csr_decode u_decode (
        .valid_i    (valid_i),
        .instr_i    (instr_i),
        .rs1_data_i (rs1_data_i),
        .op_o       (op),
        .addr_o     (addr),
        .operand_o  (operand),
        .wr_req_o   (wr_req),
        .rd_we_o    (rd_we),
        .cause_o    (cause)
    );

    // execute, state changes on the accepting edge
    csr_file u_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_i        (pc_i),
        .op_i        (op),
        .addr_i      (addr),
        .operand_i   (operand),
        .wr_req_i    (wr_req),
        .cause_i     (cause),
        .rdata_o     (rdata),
        .target_pc_o (target_pc)
    );

    // outputs appear one cycle after acceptance
    csr_result u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .op_i          (op),
        .rd_we_i       (rd_we),
        .rdata_i       (rdata),
        .target_pc_i   (target_pc),
        .rd_we_o       (rd_we_o),
        .rd_data_o     (rd_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

// File: dv/csr_assert.sv
module csr_assert (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        rd_we_i,
    input logic        redirect_i,
    input logic [31:0] redirect_pc_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // a trap or mret never writes rd
    property no_we_with_redirect;
        @(posedge clk_i) disable iff (!rst_n_i) !(redirect_i && rd_we_i);
    endproperty

    // redirect targets are word aligned
    property redirect_aligned;
        @(posedge clk_i) disable iff (!rst_n_i)
            redirect_i |-> (redirect_pc_i[1:0] == 2'b00);
    endproperty

    property quiet_after_reset;
        @(posedge clk_i) $rose(rst_n_i) |-> (!rd_we_i && !redirect_i);
    endproperty

    a_no_we_with_redirect: assert property (no_we_with_redirect)
        else $error("rd_we_o and redirect_o are high together");

    a_redirect_aligned: assert property (redirect_aligned)
        else $error("redirect_pc_o is not word aligned");

    a_quiet_after_reset: assert property (quiet_after_reset)
        else $error("control outputs not low after reset");

endmodule

// File: dv/csr_clk_gen.sv
module csr_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // release on a rising edge, like a synchronized reset
    initial begin
        rst_n_o <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: dv/csr_patterns.txt
// instr    pc       rs1_data exp_we exp_rd_data exp_redirect exp_redirect_pc
// reset values
300020F3 00000000 00000000 1 00001800 0 00000000
305020F3 00000004 00000000 1 00000000 0 00000000
341020F3 00000008 00000000 1 00000000 0 00000000
342020F3 0000000C 00000000 1 00000000 0 00000000
// csrrw to mtvec and mepc, low bits dropped
305110F3 00000010 00000103 1 00000000 0 00000000
341110F3 00000014 00002007 1 00000000 0 00000000
305020F3 00000018 00000000 1 00000100 0 00000000
341020F3 0000001C 00000000 1 00002004 0 00000000
// set and clear on mstatus, zero source is a pure read
300120F3 00000020 FFFFFFFF 1 00001800 0 00000000
300130F3 00000024 00000008 1 00001888 0 00000000
300460F3 00000028 FFFFFFFF 1 00001880 0 00000000
300070F3 0000002C FFFFFFFF 1 00001888 0 00000000
300030F3 00000030 FFFFFFFF 1 00001888 0 00000000
30047073 00000034 00000000 0 00001888 0 00000000
300020F3 00000038 00000000 1 00001880 0 00000000
30013073 0000003C 00000080 0 00001880 0 00000000
30046073 00000040 00000000 0 00001800 0 00000000
// ecall with MIE set, MPIE clear
00000073 00000400 00000000 0 00000000 1 00000100
341020F3 00000404 00000000 1 00000400 0 00000000
342020F3 00000408 00000000 1 0000000B 0 00000000
300020F3 0000040C 00000000 1 00001880 0 00000000
// mret back to mepc
30200073 00000500 00000000 0 00000000 1 00000400
300020F3 00000400 00000000 1 00001888 0 00000000
// unknown csr address
7C0110F3 00000600 12345678 0 00000000 1 00000100
342020F3 00000604 00000000 1 00000002 0 00000000
341020F3 00000608 00000000 1 00000600 0 00000000
342110F3 0000060C DEADBEEF 1 00000002 0 00000000
342020F3 00000610 00000000 1 DEADBEEF 0 00000000
300110F3 00000614 00000000 1 00001880 0 00000000
300020F3 00000618 00000000 1 00001800 0 00000000
// reserved funct3 under SYSTEM
300040F3 00000700 00000000 0 00000000 1 00000100
341020F3 00000704 00000000 1 00000700 0 00000000

// File: dv/csr_tb.sv
module csr_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PATTERNS   = 32;
    localparam int NUM_COLUMNS    = 7;
    localparam int TIMEOUT_CYCLES = NUM_PATTERNS + 20;

    logic        clk;
    logic        rst_n;
    logic        valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic        rd_we;
    logic [31:0] rd_data;
    logic        redirect;
    logic [31:0] redirect_pc;

    // seven words per instruction row
    logic [31:0] pat_mem [0:NUM_PATTERNS*NUM_COLUMNS-1];
    int          cycle_count = 0;

    csr_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    csr_unit_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_i       (valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .rs1_data_i    (rs1_data),
        .rd_we_o       (rd_we),
        .rd_data_o     (rd_data),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    bind csr_unit_top csr_assert u_assert (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .rd_we_i       (rd_we_o),
        .redirect_i    (redirect_o),
        .redirect_pc_i (redirect_pc_o)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
            abort_run($sformatf("wrong value on %s", name));
        end
    endtask

    task automatic drive_pattern(input int idx);
        valid    <= 1'b1;
        instr    <= pat_mem[idx*NUM_COLUMNS + 0];
        pc       <= pat_mem[idx*NUM_COLUMNS + 1];
        rs1_data <= pat_mem[idx*NUM_COLUMNS + 2];
    endtask

    // columns 3 to 6 hold the expected outputs
    task automatic expect_outputs(input int idx);
        check_word("rd_we_o", {31'b0, rd_we}, pat_mem[idx*NUM_COLUMNS + 3]);
        check_word("rd_data_o", rd_data, pat_mem[idx*NUM_COLUMNS + 4]);
        check_word("redirect_o", {31'b0, redirect}, pat_mem[idx*NUM_COLUMNS + 5]);
        check_word("redirect_pc_o", redirect_pc, pat_mem[idx*NUM_COLUMNS + 6]);
    endtask

    // watchdog counted from reset release
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                abort_run($sformatf("timeout: run still going after %0d cycles",
                                    TIMEOUT_CYCLES));
            end
        end
    end

    initial begin
        int i;
        valid    <= 1'b0;
        instr    <= '0;
        pc       <= '0;
        rs1_data <= '0;
        $readmemh("dv/csr_patterns.txt", pat_mem);

        wait (rst_n === 1'b1);
        @(negedge clk);
        check_word("rd_we_o", {31'b0, rd_we}, 32'h0);
        check_word("redirect_o", {31'b0, redirect}, 32'h0);

        // results of row i-1 show while row i is driven
        for (i = 0; i < NUM_PATTERNS; i++) begin
            @(posedge clk);
            drive_pattern(i);
            @(negedge clk);
            if (i > 0) begin
                expect_outputs(i - 1);
            end
        end
        @(posedge clk);
        valid <= 1'b0;
        @(negedge clk);
        expect_outputs(NUM_PATTERNS - 1);

        // last instruction word still held with valid low
        @(negedge clk);
        check_word("rd_we_o", {31'b0, rd_we}, 32'h0);
        check_word("redirect_o", {31'b0, redirect}, 32'h0);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
